/* common/roce_pkg.sv */
`default_nettype none

package roce_pkg;

  localparam int QPN_W = 24;
  localparam int PSN_W = 24;

  // Queue pair number and packet sequence number as carried in the BTH
  typedef logic [QPN_W-1:0] qpn_t;
  typedef logic [PSN_W-1:0] psn_t;

  // RC opcodes that end a message
  localparam logic [7:0] RC_SEND_LAST           = 8'h02;
  localparam logic [7:0] RC_SEND_LAST_IMD       = 8'h03;
  localparam logic [7:0] RC_SEND_ONLY           = 8'h04;
  localparam logic [7:0] RC_SEND_ONLY_IMD       = 8'h05;
  localparam logic [7:0] RC_RDMA_WRITE_LAST     = 8'h08;
  localparam logic [7:0] RC_RDMA_WRITE_LAST_IMD = 8'h09;
  localparam logic [7:0] RC_RDMA_WRITE_ONLY     = 8'h0A;
  localparam logic [7:0] RC_RDMA_WRITE_ONLY_IMD = 8'h0B;

  localparam logic [7:0] RC_RDMA_ACK = 8'h11;

  // AETH syndrome class in bits 6:5
  localparam logic [1:0] AETH_CLASS_ACK = 2'b00;
  localparam logic [1:0] AETH_CLASS_NAK = 2'b11;

  // NAK code in bits 4:0
  localparam logic [4:0] AETH_NAK_PSN_SEQ = 5'd0;

endpackage

`default_nettype wire

/* common/qp_pkg.sv */
`default_nettype none

package qp_pkg;

  localparam int QP_COUNT   = 4;
  localparam int QP_INDEX_W = 2;
  localparam int QPN_BASE   = 256;

  typedef logic [QP_INDEX_W-1:0] qp_index_t;

  typedef enum logic [2:0] {
    QP_STATE_RESET    = 3'd0,
    QP_STATE_INIT     = 3'd1,
    QP_STATE_RTR      = 3'd2,
    QP_STATE_RTS      = 3'd3,
    QP_STATE_SQ_DRAIN = 3'd4,
    QP_STATE_SQ_ERROR = 3'd5,
    QP_STATE_ERROR    = 3'd6
  } qp_state_e;

  // Codes 0 and 4..7 are not valid host requests
  typedef enum logic [2:0] {
    REQ_OPEN_QP       = 3'd1,
    REQ_MODIFY_QP_RTS = 3'd2,
    REQ_CLOSE_QP      = 3'd3
  } qp_req_e;

  typedef struct packed {
    qp_state_e      state;
    logic [31:0]    rem_ip_addr;
    roce_pkg::qpn_t rem_qpn;
    roce_pkg::qpn_t loc_qpn;
    roce_pkg::psn_t rem_psn;
    roce_pkg::psn_t loc_psn;
    logic [63:0]    rem_addr;
    logic [31:0]    r_key;
    logic [7:0]     syndrome;
  } qp_context_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_OPEN,
    CMD_MODIFY_RTS,
    CMD_CLOSE,
    CMD_TX_UPDATE,
    CMD_RX_ERROR
  } qp_cmd_e;

  typedef struct packed {
    qp_cmd_e        op;
    qp_index_t      index;
    roce_pkg::psn_t psn;
    logic [7:0]     syndrome;
    qp_context_t    ctx;
  } qp_cmd_t;

  function automatic logic qpn_in_range(roce_pkg::qpn_t qpn);
    return (qpn >= QPN_BASE) && (qpn < QPN_BASE + QP_COUNT);
  endfunction

  function automatic qp_index_t qpn_index(roce_pkg::qpn_t qpn);
    roce_pkg::qpn_t offset;
    offset = qpn - roce_pkg::qpn_t'(QPN_BASE);
    return offset[QP_INDEX_W-1:0];
  endfunction

endpackage

`default_nettype wire

/* design/qp_context_reader.sv */
`default_nettype none

module qp_context_reader (
  input  wire  logic                 clk,
  input  wire  logic                 rst,

  input  wire  logic                 qp_context_req,
  input  wire  roce_pkg::qpn_t       qp_local_qpn_req,

  output qp_pkg::qp_index_t          rd_index,
  input  wire  qp_pkg::qp_context_t  rd_context,

  output logic                       qp_req_context_valid,
  output qp_pkg::qp_state_e          qp_req_state,
  output logic [31:0]                qp_req_r_key,
  output roce_pkg::qpn_t             qp_req_rem_qpn,
  output roce_pkg::qpn_t             qp_req_loc_qpn,
  output roce_pkg::psn_t             qp_req_rem_psn,
  output roce_pkg::psn_t             qp_req_loc_psn,
  output logic [31:0]                qp_req_rem_ip_addr,
  output logic [63:0]                qp_req_rem_addr,
  output logic [7:0]                 qp_req_syndrome
);

  import qp_pkg::*;

  logic        valid_s1;
  logic        valid_s2;
  qp_context_t ctx_s1;
  qp_context_t ctx_s2;

  assign rd_index = qpn_index(qp_local_qpn_req);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
    end else begin
      // Out of range lookups never reach the output
      valid_s1 <= qp_context_req && qpn_in_range(qp_local_qpn_req);
      valid_s2 <= valid_s1;
    end
    ctx_s1 <= rd_context;
    ctx_s2 <= ctx_s1;
  end

  assign qp_req_context_valid = valid_s2;
  assign qp_req_state         = ctx_s2.state;
  assign qp_req_r_key         = ctx_s2.r_key;
  assign qp_req_rem_qpn       = ctx_s2.rem_qpn;
  assign qp_req_loc_qpn       = ctx_s2.loc_qpn;
  assign qp_req_rem_psn       = ctx_s2.rem_psn;
  assign qp_req_loc_psn       = ctx_s2.loc_psn;
  assign qp_req_rem_ip_addr   = ctx_s2.rem_ip_addr;
  assign qp_req_rem_addr      = ctx_s2.rem_addr;
  assign qp_req_syndrome      = ctx_s2.syndrome;

endmodule

`default_nettype wire

/* qp_state/qp_cmd_decoder.sv */
`default_nettype none

module qp_cmd_decoder (
  input  wire  logic             clk,
  input  wire  logic             rst,

  input  wire  logic             qp_init_valid,
  input  wire  qp_pkg::qp_req_e  qp_init_req_type,
  input  wire  logic [31:0]      qp_init_r_key,
  input  wire  roce_pkg::qpn_t   qp_init_rem_qpn,
  input  wire  roce_pkg::qpn_t   qp_init_loc_qpn,
  input  wire  roce_pkg::psn_t   qp_init_rem_psn,
  input  wire  roce_pkg::psn_t   qp_init_loc_psn,
  input  wire  logic [31:0]      qp_init_rem_ip_addr,
  input  wire  logic [63:0]      qp_init_rem_addr,

  input  wire  logic             tx_bth_valid,
  input  wire  logic [7:0]       tx_bth_op_code,
  input  wire  roce_pkg::psn_t   tx_bth_psn,
  input  wire  roce_pkg::qpn_t   tx_bth_src_qp,

  input  wire  logic             rx_bth_valid,
  input  wire  logic [7:0]       rx_bth_op_code,
  input  wire  roce_pkg::qpn_t   rx_bth_dest_qp,
  input  wire  logic             rx_aeth_valid,
  input  wire  logic [7:0]       rx_aeth_syndrome,

  output qp_pkg::qp_cmd_t        cmd
);

  import roce_pkg::*;
  import qp_pkg::*;

  logic      busy;
  logic      tx_hit;
  logic      init_hit;
  logic      rx_hit;
  qp_cmd_e   next_op;
  qp_index_t next_index;

  // Only the last packet of a message advances the remote PSN
  assign tx_hit = tx_bth_valid && qpn_in_range(tx_bth_src_qp) &&
                  (tx_bth_op_code inside {RC_SEND_LAST, RC_SEND_LAST_IMD,
                                          RC_SEND_ONLY, RC_SEND_ONLY_IMD,
                                          RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_LAST_IMD,
                                          RC_RDMA_WRITE_ONLY, RC_RDMA_WRITE_ONLY_IMD});

  assign init_hit = qp_init_valid && qpn_in_range(qp_init_loc_qpn) &&
                    (qp_init_req_type inside {REQ_OPEN_QP, REQ_MODIFY_QP_RTS, REQ_CLOSE_QP});

  // PSN sequence errors are recovered by retransmission, not by ERROR
  assign rx_hit = rx_bth_valid && rx_aeth_valid && qpn_in_range(rx_bth_dest_qp) &&
                  (rx_bth_op_code == RC_RDMA_ACK) &&
                  (rx_aeth_syndrome[6:5] == AETH_CLASS_NAK) &&
                  (rx_aeth_syndrome[4:0] != AETH_NAK_PSN_SEQ);

  always_comb begin
    next_op    = CMD_NONE;
    next_index = qpn_index(qp_init_loc_qpn);
    if (!busy) begin
      if (tx_hit) begin
        next_op    = CMD_TX_UPDATE;
        next_index = qpn_index(tx_bth_src_qp);
      end else if (init_hit) begin
        case (qp_init_req_type)
          REQ_OPEN_QP:       next_op = CMD_OPEN;
          REQ_MODIFY_QP_RTS: next_op = CMD_MODIFY_RTS;
          REQ_CLOSE_QP:      next_op = CMD_CLOSE;
          default:           next_op = CMD_NONE;
        endcase
      end
      // NAK wins over everything else
      if (rx_hit) begin
        next_op    = CMD_RX_ERROR;
        next_index = qpn_index(rx_bth_dest_qp);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      cmd.op <= CMD_NONE;
    end else begin
      busy   <= (next_op != CMD_NONE);
      cmd.op <= next_op;
    end
    cmd.index    <= next_index;
    cmd.psn      <= tx_bth_psn + psn_t'(1);
    cmd.syndrome <= rx_hit ? rx_aeth_syndrome : 8'd0;
    cmd.ctx      <= '{state:       QP_STATE_INIT,
                      rem_ip_addr: qp_init_rem_ip_addr,
                      rem_qpn:     qp_init_rem_qpn,
                      loc_qpn:     qp_init_loc_qpn,
                      rem_psn:     qp_init_rem_psn,
                      loc_psn:     qp_init_loc_psn,
                      rem_addr:    qp_init_rem_addr,
                      r_key:       qp_init_r_key,
                      syndrome:    8'd0};
  end

endmodule

`default_nettype wire

/* qp_state/qp_context_table.sv */
`default_nettype none

module qp_context_table (
  input  wire  logic               clk,
  input  wire  logic               rst,

  input  wire  qp_pkg::qp_cmd_t    cmd,

  input  wire  qp_pkg::qp_index_t  rd_index,
  output qp_pkg::qp_context_t      rd_context,

  output logic                     qp_init_status_valid,
  output logic [1:0]               qp_init_status
);

  import qp_pkg::*;

  qp_context_t ctx_mem [QP_COUNT];
  qp_context_t cur_entry;
  logic        state_ok;
  logic        is_request;
  logic        status_err;

  assign cur_entry = ctx_mem[cmd.index];

  // Legal state transitions for host requests
  always_comb begin
    case (cmd.op)
      CMD_OPEN:       state_ok = (cur_entry.state == QP_STATE_RESET);
      CMD_MODIFY_RTS: state_ok = (cur_entry.state == QP_STATE_INIT);
      CMD_CLOSE:      state_ok = (cur_entry.state != QP_STATE_RESET);
      default:        state_ok = 1'b1;
    endcase
  end

  assign is_request = (cmd.op inside {CMD_OPEN, CMD_MODIFY_RTS, CMD_CLOSE});

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < QP_COUNT; i++) begin
        ctx_mem[i] <= '0;
      end
      qp_init_status_valid <= 1'b0;
    end else begin
      qp_init_status_valid <= is_request;
      if (state_ok) begin
        case (cmd.op)
          CMD_OPEN: begin
            ctx_mem[cmd.index] <= cmd.ctx;
          end
          CMD_MODIFY_RTS: begin
            ctx_mem[cmd.index].state <= QP_STATE_RTS;
          end
          CMD_CLOSE: begin
            ctx_mem[cmd.index].state    <= QP_STATE_RESET;
            ctx_mem[cmd.index].syndrome <= 8'd0;
          end
          CMD_TX_UPDATE: begin
            ctx_mem[cmd.index].rem_psn  <= cmd.psn;
            ctx_mem[cmd.index].syndrome <= cmd.syndrome;
          end
          CMD_RX_ERROR: begin
            ctx_mem[cmd.index].state    <= QP_STATE_ERROR;
            ctx_mem[cmd.index].syndrome <= cmd.syndrome;
          end
          default: begin
          end
        endcase
      end
    end
    status_err <= !state_ok;
  end

  // Upper bit flags a refused transition
  assign qp_init_status = {status_err, 1'b0};

  assign rd_context = ctx_mem[rd_index];

endmodule

`default_nettype wire

/* qp_state/qp_state_top.sv */
`default_nettype none

module qp_state_top (
  input  wire  logic                clk,
  input  wire  logic                rst,

  input  wire  logic                qp_init_valid,
  input  wire  qp_pkg::qp_req_e     qp_init_req_type,
  input  wire  logic [31:0]         qp_init_r_key,
  input  wire  roce_pkg::qpn_t      qp_init_rem_qpn,
  input  wire  roce_pkg::qpn_t      qp_init_loc_qpn,
  input  wire  roce_pkg::psn_t      qp_init_rem_psn,
  input  wire  roce_pkg::psn_t      qp_init_loc_psn,
  input  wire  logic [31:0]         qp_init_rem_ip_addr,
  input  wire  logic [63:0]         qp_init_rem_addr,
  output logic                      qp_init_status_valid,
  output logic [1:0]                qp_init_status,

  input  wire  logic                tx_bth_valid,
  input  wire  logic [7:0]          tx_bth_op_code,
  input  wire  roce_pkg::psn_t      tx_bth_psn,
  input  wire  roce_pkg::qpn_t      tx_bth_src_qp,

  input  wire  logic                rx_bth_valid,
  input  wire  logic [7:0]          rx_bth_op_code,
  input  wire  roce_pkg::qpn_t      rx_bth_dest_qp,
  input  wire  logic                rx_aeth_valid,
  input  wire  logic [7:0]          rx_aeth_syndrome,

  input  wire  logic                qp_context_req,
  input  wire  roce_pkg::qpn_t      qp_local_qpn_req,
  output logic                      qp_req_context_valid,
  output qp_pkg::qp_state_e         qp_req_state,
  output logic [31:0]               qp_req_r_key,
  output roce_pkg::qpn_t            qp_req_rem_qpn,
  output roce_pkg::qpn_t            qp_req_loc_qpn,
  output roce_pkg::psn_t            qp_req_rem_psn,
  output roce_pkg::psn_t            qp_req_loc_psn,
  output logic [31:0]               qp_req_rem_ip_addr,
  output logic [63:0]               qp_req_rem_addr,
  output logic [7:0]                qp_req_syndrome
);

  import qp_pkg::*;

  qp_cmd_t     cmd;
  qp_index_t   rd_index;
  qp_context_t rd_context;

  qp_cmd_decoder u_decoder (
    .clk, .rst,
    .qp_init_valid, .qp_init_req_type, .qp_init_r_key,
    .qp_init_rem_qpn, .qp_init_loc_qpn, .qp_init_rem_psn, .qp_init_loc_psn,
    .qp_init_rem_ip_addr, .qp_init_rem_addr,
    .tx_bth_valid, .tx_bth_op_code, .tx_bth_psn, .tx_bth_src_qp,
    .rx_bth_valid, .rx_bth_op_code, .rx_bth_dest_qp,
    .rx_aeth_valid, .rx_aeth_syndrome,
    .cmd
  );

  qp_context_table u_table (
    .clk, .rst,
    .cmd, .rd_index, .rd_context,
    .qp_init_status_valid, .qp_init_status
  );

  qp_context_reader u_reader (
    .clk, .rst,
    .qp_context_req, .qp_local_qpn_req,
    .rd_index, .rd_context,
    .qp_req_context_valid, .qp_req_state, .qp_req_r_key,
    .qp_req_rem_qpn, .qp_req_loc_qpn, .qp_req_rem_psn, .qp_req_loc_psn,
    .qp_req_rem_ip_addr, .qp_req_rem_addr, .qp_req_syndrome
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 5;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Release just after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #5 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_qp_state.sv */
`default_nettype none

module tb_qp_state;

  timeunit 1ns;
  timeprecision 100ps;

  import roce_pkg::*;
  import qp_pkg::*;

  localparam int EV_INIT = 0;
  localparam int EV_TX   = 1;
  localparam int EV_RX   = 2;
  // Reset, 20 events of 4 cycles, 8 read bursts of up to 8 cycles, drain
  localparam int STIM_CYCLES    = 5 + 20 * 4 + 8 * 8 + 10;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

  logic        clk;
  logic        rst;
  logic        qp_init_valid;
  qp_req_e     qp_init_req_type;
  logic [31:0] qp_init_r_key;
  qpn_t        qp_init_rem_qpn;
  qpn_t        qp_init_loc_qpn;
  psn_t        qp_init_rem_psn;
  psn_t        qp_init_loc_psn;
  logic [31:0] qp_init_rem_ip_addr;
  logic [63:0] qp_init_rem_addr;
  logic        qp_init_status_valid;
  logic [1:0]  qp_init_status;
  logic        tx_bth_valid;
  logic [7:0]  tx_bth_op_code;
  psn_t        tx_bth_psn;
  qpn_t        tx_bth_src_qp;
  logic        rx_bth_valid;
  logic [7:0]  rx_bth_op_code;
  qpn_t        rx_bth_dest_qp;
  logic        rx_aeth_valid;
  logic [7:0]  rx_aeth_syndrome;
  logic        qp_context_req;
  qpn_t        qp_local_qpn_req;
  logic        qp_req_context_valid;
  qp_state_e   qp_req_state;
  logic [31:0] qp_req_r_key;
  qpn_t        qp_req_rem_qpn;
  qpn_t        qp_req_loc_qpn;
  psn_t        qp_req_rem_psn;
  psn_t        qp_req_loc_psn;
  logic [31:0] qp_req_rem_ip_addr;
  logic [63:0] qp_req_rem_addr;
  logic [7:0]  qp_req_syndrome;

  int          seed;
  int          cycle_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  qp_context_t model [QP_COUNT];
  logic [1:0]  exp_status [$];
  int          exp_status_cycle [$];
  qp_context_t exp_ctx [$];
  int          exp_ctx_cycle [$];

  tb_clock_gen u_clk_gen (.clk, .rst);

  qp_state_top uut (.*);

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Expected context after one event
  function automatic qp_context_t ref_next(input qp_context_t cur, input int kind,
                                           input logic [2:0] req, input qp_context_t load,
                                           input logic [7:0] op, input psn_t psn,
                                           input logic [7:0] syn, output logic err);
    qp_context_t nxt;
    nxt = cur;
    err = 1'b0;
    if (kind == EV_INIT) begin
      case (req)
        3'd1: begin
          err = (cur.state != QP_STATE_RESET);
          if (!err) begin
            nxt = load;
            nxt.state = QP_STATE_INIT;
            nxt.syndrome = 8'd0;
          end
        end
        3'd2: begin
          err = (cur.state != QP_STATE_INIT);
          if (!err) begin
            nxt.state = QP_STATE_RTS;
          end
        end
        3'd3: begin
          err = (cur.state == QP_STATE_RESET);
          if (!err) begin
            nxt.state = QP_STATE_RESET;
            nxt.syndrome = 8'd0;
          end
        end
        default: begin
        end
      endcase
    end else if (kind == EV_TX) begin
      if (op inside {RC_SEND_LAST, RC_SEND_LAST_IMD, RC_SEND_ONLY, RC_SEND_ONLY_IMD,
                     RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_LAST_IMD,
                     RC_RDMA_WRITE_ONLY, RC_RDMA_WRITE_ONLY_IMD}) begin
        nxt.rem_psn = psn + 24'd1;
        nxt.syndrome = 8'd0;
      end
    end else if (op == RC_RDMA_ACK && syn[6:5] == AETH_CLASS_NAK &&
                 syn[4:0] != AETH_NAK_PSN_SEQ) begin
      nxt.state = QP_STATE_ERROR;
      nxt.syndrome = syn;
    end
    return nxt;
  endfunction

  task automatic clear_strobes();
    qp_init_valid = 1'b0;
    tx_bth_valid = 1'b0;
    rx_bth_valid = 1'b0;
    rx_aeth_valid = 1'b0;
    qp_context_req = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #5;
      clear_strobes();
    end
  endtask

  task automatic send_event(input int kind, input logic [2:0] req, input qpn_t qpn,
                            input qp_context_t load, input logic [7:0] op,
                            input psn_t psn, input logic [7:0] syn);
    logic err;
    int   idx;
    @(posedge clk);
    #5;
    if (kind == EV_INIT) begin
      qp_init_valid = 1'b1;
      qp_init_req_type = qp_req_e'(req);
      qp_init_r_key = load.r_key;
      qp_init_rem_qpn = load.rem_qpn;
      qp_init_loc_qpn = qpn;
      qp_init_rem_psn = load.rem_psn;
      qp_init_loc_psn = load.loc_psn;
      qp_init_rem_ip_addr = load.rem_ip_addr;
      qp_init_rem_addr = load.rem_addr;
    end else if (kind == EV_TX) begin
      tx_bth_valid = 1'b1;
      tx_bth_op_code = op;
      tx_bth_psn = psn;
      tx_bth_src_qp = qpn;
    end else begin
      rx_bth_valid = 1'b1;
      rx_aeth_valid = 1'b1;
      rx_bth_op_code = op;
      rx_bth_dest_qp = qpn;
      rx_aeth_syndrome = syn;
    end
    if (qpn >= QPN_BASE && qpn < QPN_BASE + QP_COUNT) begin
      idx = qpn - QPN_BASE;
      model[idx] = ref_next(model[idx], kind, req, load, op, psn, syn, err);
      if (kind == EV_INIT && req inside {3'd1, 3'd2, 3'd3}) begin
        exp_status.push_back({err, 1'b0});
        exp_status_cycle.push_back(cycle_cnt + 2);
      end
    end
    idle(3);
  endtask

  task automatic open_qp(input qpn_t qpn);
    qp_context_t load;
    load = '0;
    load.r_key = $random(seed);
    load.rem_qpn = qpn_t'($random(seed));
    load.loc_qpn = qpn;
    load.rem_psn = psn_t'($random(seed));
    load.loc_psn = psn_t'($random(seed));
    load.rem_ip_addr = $random(seed);
    load.rem_addr = {$random(seed), $random(seed)};
    send_event(EV_INIT, 3'd1, qpn, load, 8'h00, '0, 8'h00);
  endtask

  task automatic issue_read(input qpn_t qpn);
    @(posedge clk);
    #5;
    clear_strobes();
    qp_context_req = 1'b1;
    qp_local_qpn_req = qpn;
    if (qpn >= QPN_BASE && qpn < QPN_BASE + QP_COUNT) begin
      exp_ctx.push_back(model[qpn - QPN_BASE]);
      exp_ctx_cycle.push_back(cycle_cnt + 2);
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_status();
    logic [1:0] e;
    int         ec;
    assert (exp_status.size() > 0) else begin
      errors++;
      $display("Status pulse at %0t with no request pending", $time);
    end
    if (exp_status.size() > 0) begin
      e = exp_status.pop_front();
      ec = exp_status_cycle.pop_front();
      assert (cycle_cnt == ec) else begin
        errors++;
        $display("Status pulse at cycle %0d, expected at cycle %0d", cycle_cnt, ec);
      end
      check_field("qp_init_status", qp_init_status, e);
    end
  endtask

  task automatic check_read();
    qp_context_t e;
    int          ec;
    assert (exp_ctx.size() > 0) else begin
      errors++;
      $display("Read valid at %0t with no read pending", $time);
    end
    if (exp_ctx.size() > 0) begin
      e = exp_ctx.pop_front();
      ec = exp_ctx_cycle.pop_front();
      assert (cycle_cnt == ec) else begin
        errors++;
        $display("Read valid at cycle %0d, expected at cycle %0d", cycle_cnt, ec);
      end
      check_field("qp_req_state", qp_req_state, e.state);
      check_field("qp_req_r_key", qp_req_r_key, e.r_key);
      check_field("qp_req_rem_qpn", qp_req_rem_qpn, e.rem_qpn);
      check_field("qp_req_loc_qpn", qp_req_loc_qpn, e.loc_qpn);
      check_field("qp_req_rem_psn", qp_req_rem_psn, e.rem_psn);
      check_field("qp_req_loc_psn", qp_req_loc_psn, e.loc_psn);
      check_field("qp_req_rem_ip_addr", qp_req_rem_ip_addr, e.rem_ip_addr);
      check_field("qp_req_rem_addr", qp_req_rem_addr, e.rem_addr);
      check_field("qp_req_syndrome", qp_req_syndrome, e.syndrome);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (qp_init_status_valid) begin
        check_status();
      end
      if (qp_req_context_valid) begin
        check_read();
      end
    end
  end

  initial begin
    seed = 32'hcaa333af;
    for (int i = 0; i < QP_COUNT; i++) begin
      model[i] = '0;
    end
    clear_strobes();
    qp_init_req_type = REQ_OPEN_QP;
    qp_init_r_key = '0;
    qp_init_rem_qpn = '0;
    qp_init_loc_qpn = '0;
    qp_init_rem_psn = '0;
    qp_init_loc_psn = '0;
    qp_init_rem_ip_addr = '0;
    qp_init_rem_addr = '0;
    tx_bth_op_code = '0;
    tx_bth_psn = '0;
    tx_bth_src_qp = '0;
    rx_bth_op_code = '0;
    rx_bth_dest_qp = '0;
    rx_aeth_syndrome = '0;
    qp_local_qpn_req = '0;
    wait (rst === 1'b1);
    wait (rst === 1'b0);

    // Contents after reset
    for (int q = 0; q < QP_COUNT; q++) begin
      issue_read(QPN_BASE + q);
    end
    idle(3);

    for (int q = 0; q < QP_COUNT; q++) begin
      open_qp(QPN_BASE + q);
    end
    for (int q = 0; q < QP_COUNT; q++) begin
      issue_read(QPN_BASE + q);
    end
    idle(3);
    open_qp(256);
    open_qp(300);
    issue_read(256);
    idle(3);

    // Legal and refused modify and close requests
    send_event(EV_INIT, 3'd2, 256, '0, 8'h00, '0, 8'h00);
    send_event(EV_INIT, 3'd2, 256, '0, 8'h00, '0, 8'h00);
    send_event(EV_INIT, 3'd2, 257, '0, 8'h00, '0, 8'h00);
    send_event(EV_INIT, 3'd3, 258, '0, 8'h00, '0, 8'h00);
    send_event(EV_INIT, 3'd3, 258, '0, 8'h00, '0, 8'h00);
    send_event(EV_INIT, 3'd2, 258, '0, 8'h00, '0, 8'h00);
    issue_read(256);
    issue_read(257);
    issue_read(258);
    idle(3);

    // TX headers ending with SEND_FIRST and WRITE_MIDDLE
    send_event(EV_TX, 3'd0, 256, '0, RC_RDMA_WRITE_ONLY, psn_t'($random(seed)), 8'h00);
    send_event(EV_TX, 3'd0, 257, '0, RC_SEND_LAST, 24'hffffff, 8'h00);
    send_event(EV_TX, 3'd0, 259, '0, 8'h00, psn_t'($random(seed)), 8'h00);
    send_event(EV_TX, 3'd0, 259, '0, 8'h07, psn_t'($random(seed)), 8'h00);
    issue_read(256);
    issue_read(257);
    issue_read(259);
    idle(3);

    // NAK with code 1, PSN sequence NAK, plain ACK
    send_event(EV_RX, 3'd0, 257, '0, RC_RDMA_ACK, '0, 8'h61);
    send_event(EV_RX, 3'd0, 256, '0, RC_RDMA_ACK, '0, 8'h60);
    send_event(EV_RX, 3'd0, 256, '0, RC_RDMA_ACK, '0, 8'h1f);
    issue_read(256);
    issue_read(257);
    idle(3);
    send_event(EV_INIT, 3'd3, 257, '0, 8'h00, '0, 8'h00);
    issue_read(257);
    idle(3);

    issue_read(256);
    issue_read(257);
    issue_read(300);
    issue_read(258);
    issue_read(259);
    idle(3);

    while (exp_status.size() != 0 || exp_ctx.size() != 0) begin
      @(posedge clk);
    end
    idle(4);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("Run stopped at cycle %0d before finishing, checks: %0d, errors: %0d",
             cycle_cnt, checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* qp_state.f */
common/roce_pkg.sv
common/qp_pkg.sv
design/qp_context_reader.sv
qp_state/qp_cmd_decoder.sv
qp_state/qp_context_table.sv
qp_state/qp_state_top.sv
bench/tb_clock_gen.sv
bench/tb_qp_state.sv

/* Bender.yml */
package:
  name: qp_state

sources:
  - common/roce_pkg.sv
  - common/qp_pkg.sv
  - design/qp_context_reader.sv
  - qp_state/qp_cmd_decoder.sv
  - qp_state/qp_context_table.sv
  - qp_state/qp_state_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_qp_state.sv
